// File: alu.sv
//--------------------------------------------------------------------
// combinational alu, eight operations on signed operands
// one shared adder for add, sub and inc, output selector, flags
//--------------------------------------------------------------------

module alu #(
  parameter int BW = 8
) (
  input  logic signed [BW-1:0] in_a_i,
  input  logic signed [BW-1:0] in_b_i,
  input  alu_pkg::alu_op_e     opcode_i,
  output logic signed [BW-1:0] result_o,
  output alu_pkg::alu_flags_t  flags_o
);

  import alu_pkg::*;

  //------------------------------------------------------------------
  // operand conditioning for the shared adder
  //------------------------------------------------------------------

  // second adder operand and carry-in
  logic [BW-1:0] adder_b;
  logic          adder_cin;

  // one of add, sub, inc
  logic          is_arith;

  always_comb begin
    unique case (opcode_i)
      // a - b as a + ~b + 1
      OP_SUB: begin
        adder_b   = ~in_b_i;
        adder_cin = 1'b1;
      end
      // a + 0 + 1
      OP_INC: begin
        adder_b   = '0;
        adder_cin = 1'b1;
      end
      // add, and don't care for the rest
      default: begin
        adder_b   = in_b_i;
        adder_cin = 1'b0;
      end
    endcase
  end

  assign is_arith = opcode_i inside {OP_ADD, OP_SUB, OP_INC};

  //------------------------------------------------------------------
  // candidate results
  //------------------------------------------------------------------

  logic [BW-1:0] out_arith;
  logic          arith_cout;
  logic [BW-1:0] out_and;
  logic [BW-1:0] out_or;
  logic [BW-1:0] out_xor;
  logic [BW-1:0] out_mova;
  logic [BW-1:0] out_movb;

  // carry-out feeds only the overflow cross-check below
  cl_adder #(
    .Width(BW)
  ) cl_adder_inst (
    .a_i  (in_a_i),
    .b_i  (adder_b),
    .c_i  (adder_cin),
    .sum_o(out_arith),
    .c_o  (arith_cout)
  );

  assign out_and  = in_a_i & in_b_i;
  assign out_or   = in_a_i | in_b_i;
  assign out_xor  = in_a_i ^ in_b_i;
  assign out_mova = in_a_i;
  assign out_movb = in_b_i;

  // concatenation order follows the opcode values, add first
  mux #(
    .BitWidth(BW),
    .N       (8)
  ) result_mux (
    .d_i  ({out_arith, out_arith, out_and, out_or,
            out_xor, out_arith, out_mova, out_movb}),
    .sel_i(opcode_i),
    .d_o  (result_o)
  );

  //------------------------------------------------------------------
  // flags
  //------------------------------------------------------------------

  // signed overflow, operands of equal sign and a sum of the other sign
  assign flags_o.overflow = is_arith
                          & (in_a_i[BW-1] == adder_b[BW-1])
                          & (out_arith[BW-1] != in_a_i[BW-1]);
  assign flags_o.negative = result_o[BW-1];
  assign flags_o.zero     = (result_o == '0);

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------

  // candidate the opcode names, taken without the selector
  logic [BW-1:0] picked;
  // carry into the msb, recovered from the sum bit
  logic          msb_cin;

  always_comb begin
    case (opcode_i)
      OP_AND:  picked = out_and;
      OP_OR:   picked = out_or;
      OP_XOR:  picked = out_xor;
      OP_MOVA: picked = out_mova;
      OP_MOVB: picked = out_movb;
      default: picked = out_arith;
    endcase
  end

  assign msb_cin = out_arith[BW-1] ^ in_a_i[BW-1] ^ adder_b[BW-1];

  // selector order and zero flag against the opcode's own candidate
  always_comb begin
    assert final ((result_o == picked) && (flags_o.zero == (picked == '0)))
      else $error("alu: result or zero flag disagrees with the opcode");
  end

  // overflow as carry into msb xor carry out, clear for logic and moves
  always_comb begin
    assert final (flags_o.overflow == (is_arith && (msb_cin ^ arith_cout)))
      else $error("alu: overflow flag disagrees with the adder carries");
  end

endmodule

// File: alu_datapath.sv
//--------------------------------------------------------------------
// execute stage top, register block feeding the alu
// operand b from register or immediate, one-cycle writeback
//--------------------------------------------------------------------

module alu_datapath #(
  parameter int BW = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            instr_valid_i,
  input  alu_pkg::alu_op_e                op_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  rs_a_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  rs_b_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  rd_i,
  input  logic                            use_imm_i,
  input  logic [BW-1:0]                   imm_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  dbg_addr_i,
  output logic [BW-1:0]                   result_o,
  output alu_pkg::alu_flags_t             flags_o,
  output logic [BW-1:0]                   dbg_data_o
);

  import alu_pkg::*;

  // register reads
  logic [BW-1:0] rd_a;
  logic [BW-1:0] rd_b;

  // operand b after immediate selection
  logic [BW-1:0] op_b;

  // alu outputs on their way to writeback
  logic [BW-1:0] alu_result;
  alu_flags_t    alu_flags;

  assign op_b = use_imm_i ? imm_i : rd_b;

  datapath_regs #(
    .BW(BW)
  ) datapath_regs_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .we_i       (instr_valid_i),
    .wr_addr_i  (rd_i),
    .rd_a_addr_i(rs_a_i),
    .rd_b_addr_i(rs_b_i),
    .dbg_addr_i (dbg_addr_i),
    .wr_data_i  (alu_result),
    .wr_flags_i (alu_flags),
    .rd_a_o     (rd_a),
    .rd_b_o     (rd_b),
    .dbg_data_o (dbg_data_o),
    .result_o   (result_o),
    .flags_o    (flags_o)
  );

  // purely combinational, result lands in the registers next edge
  alu #(
    .BW(BW)
  ) alu_inst (
    .in_a_i  (rd_a),
    .in_b_i  (op_b),
    .opcode_i(op_i),
    .result_o(alu_result),
    .flags_o (alu_flags)
  );

endmodule

// File: alu_pkg.sv
//--------------------------------------------------------------------
// shared definitions for the execute-stage datapath
// operation encoding, status flag layout, register address width
//--------------------------------------------------------------------

package alu_pkg;

  //------------------------------------------------------------------
  // register file addressing
  //------------------------------------------------------------------

  // four architectural registers r0..r3
  localparam int REG_ADDR_W = 2;

  //------------------------------------------------------------------
  // operation codes
  //------------------------------------------------------------------

  // order matches the selector input order in the alu
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,  // a + b
    OP_SUB  = 3'd1,  // a - b
    OP_AND  = 3'd2,  // bitwise and
    OP_OR   = 3'd3,  // bitwise or
    OP_XOR  = 3'd4,  // bitwise xor
    OP_INC  = 3'd5,  // a + 1
    OP_MOVA = 3'd6,  // pass a
    OP_MOVB = 3'd7   // pass b (register or immediate)
  } alu_op_e;

  //------------------------------------------------------------------
  // status flags
  //------------------------------------------------------------------

  // bit 2 overflow, bit 1 negative, bit 0 zero
  typedef struct packed {
    logic overflow;  // signed overflow of add, sub, inc
    logic negative;  // msb of the result
    logic zero;      // result is all zeros
  } alu_flags_t;

endpackage

// File: cl_adder.sv
//--------------------------------------------------------------------
// carry-lookahead adder, parameterized width
// per-bit generate/propagate, lookahead carries, sum and carry-out
//--------------------------------------------------------------------

module cl_adder #(
  parameter int Width = 8
) (
  input  logic [Width-1:0] a_i,
  input  logic [Width-1:0] b_i,
  input  logic             c_i,
  output logic [Width-1:0] sum_o,
  output logic             c_o
);

  // per-bit generate and propagate
  logic [Width-1:0] gen;
  logic [Width-1:0] prop;

  // carry into each bit, carry[Width] is the carry-out
  logic [Width:0] carry;

  // carry into bit idx, flattened sum of products
  // g[j] survives when every propagate above it up to idx-1 is set
  function automatic logic carry_into(
    input logic [Width-1:0] g,
    input logic [Width-1:0] p,
    input logic             cin,
    input int               idx
  );
    logic c;
    logic run_p;
    c = 1'b0;
    run_p = 1'b1;
    // walk down from the bit just below idx
    for (int j = Width - 1; j >= 0; j--) begin
      if (j < idx) begin
        c = c | (run_p & g[j]);
        run_p = run_p & p[j];
      end
    end
    // carry-in only reaches idx through every propagate below it
    c = c | (run_p & cin);
    return c;
  endfunction

  assign gen  = a_i & b_i;
  assign prop = a_i ^ b_i;

  // every carry formed straight from c_i, no ripple
  for (genvar i = 0; i <= Width; i++) begin : gen_carry
    assign carry[i] = carry_into(gen, prop, c_i, i);
  end

  // xor propagate doubles as the half-sum
  assign sum_o = prop ^ carry[Width-1:0];
  assign c_o   = carry[Width];

endmodule

// File: datapath_regs.sv
//--------------------------------------------------------------------
// register block beside the alu
// four-entry register file, two read ports, one write port,
// result and status flag registers, debug read port
//--------------------------------------------------------------------

module datapath_regs #(
  parameter int BW = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            we_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  wr_addr_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  rd_a_addr_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  rd_b_addr_i,
  input  logic [alu_pkg::REG_ADDR_W-1:0]  dbg_addr_i,
  input  logic [BW-1:0]                   wr_data_i,
  input  alu_pkg::alu_flags_t             wr_flags_i,
  output logic [BW-1:0]                   rd_a_o,
  output logic [BW-1:0]                   rd_b_o,
  output logic [BW-1:0]                   dbg_data_o,
  output logic [BW-1:0]                   result_o,
  output alu_pkg::alu_flags_t             flags_o
);

  import alu_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  //------------------------------------------------------------------
  // storage
  //------------------------------------------------------------------

  logic [BW-1:0] rf_q [NUM_REGS];
  logic [BW-1:0] result_q;
  alu_flags_t    flags_q;

  // everything loads together on an issued instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        rf_q[r] <= '0;
      end
      result_q <= '0;
      flags_q  <= '0;
    end else if (we_i) begin
      rf_q[wr_addr_i] <= wr_data_i;
      result_q        <= wr_data_i;
      flags_q         <= wr_flags_i;
    end
  end

  //------------------------------------------------------------------
  // reads
  //------------------------------------------------------------------

  // combinational, so a dependent instruction sees last edge's write
  assign rd_a_o     = rf_q[rd_a_addr_i];
  assign rd_b_o     = rf_q[rd_b_addr_i];
  assign dbg_data_o = rf_q[dbg_addr_i];

  assign result_o = result_q;
  assign flags_o  = flags_q;

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------

  // the edge after reset leaves result and flags cleared
  assert property (@(posedge clk_i)
    $past(rst_i) |-> (result_o == '0) && (flags_o == '0))
    else $error("datapath_regs: result or flags not cleared by reset");

  // without a write they hold, so they stay zero until the first one
  assert property (@(posedge clk_i) disable iff (rst_i)
    (!$past(rst_i) && !$past(we_i)) |-> $stable(result_o) && $stable(flags_o))
    else $error("datapath_regs: result or flags changed without a write");

endmodule

// File: mux.sv
//--------------------------------------------------------------------
// n-way selector of equal-width vectors by binary select
// input 0 sits in the most significant slice of d_i
//--------------------------------------------------------------------

module mux #(
  parameter int BitWidth = 8,
  parameter int N        = 8
) (
  input  logic [N*BitWidth-1:0]  d_i,
  input  logic [$clog2(N)-1:0]   sel_i,
  output logic [BitWidth-1:0]    d_o
);

  // unpacked view of the inputs, slices[0] is the top slice
  logic [BitWidth-1:0] slices [N];

  for (genvar k = 0; k < N; k++) begin : gen_slice
    assign slices[k] = d_i[(N-k)*BitWidth-1 -: BitWidth];
  end

  // select codes past N-1 give zero when N is not a power of two
  always_comb begin
    d_o = '0;
    if (32'(sel_i) < N) begin
      d_o = slices[sel_i];
    end
  end

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------

  // an unknown opcode upstream would pick an arbitrary slice
  always_comb begin
    assert final (!$isunknown(sel_i))
      else $error("mux: select is unknown");
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile the execute-stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_alu_datapath -f src.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "no failure found in $LOG"
exit 0

// File: src.f
alu_pkg.sv
cl_adder.sv
mux.sv
alu.sv
datapath_regs.sv
alu_datapath.sv
tb_alu_datapath.sv

// File: tb_alu_datapath.sv
//--------------------------------------------------------------------
// testbench for the execute-stage datapath
// directed instruction table, shadow register model, lfsr random run,
// typed compare tasks, watchdog
//--------------------------------------------------------------------

module tb_alu_datapath;

  timeunit 1ns;
  timeprecision 100ps;

  import alu_pkg::*;

  localparam int BW          = 8;
  localparam int NUM_REGS    = 2 ** REG_ADDR_W;
  localparam int CLK_PERIOD  = 8;
  localparam int NUM_ENTRIES = 21;
  localparam int NUM_RANDOM  = 200;
  localparam int WATCHDOG_NS = (NUM_ENTRIES + NUM_RANDOM + 50) * CLK_PERIOD;

  // dut ports
  logic                  clk_i;
  logic                  rst_i;
  logic                  instr_valid_i;
  alu_op_e               op_i;
  logic [REG_ADDR_W-1:0] rs_a_i;
  logic [REG_ADDR_W-1:0] rs_b_i;
  logic [REG_ADDR_W-1:0] rd_i;
  logic                  use_imm_i;
  logic [BW-1:0]         imm_i;
  logic [REG_ADDR_W-1:0] dbg_addr_i;
  logic [BW-1:0]         result_o;
  alu_flags_t            flags_o;
  logic [BW-1:0]         dbg_data_o;

  // one table row, stimulus plus outputs expected one edge later
  typedef struct {
    logic                  issue;
    alu_op_e               op;
    logic [REG_ADDR_W-1:0] rs_a;
    logic [REG_ADDR_W-1:0] rs_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  use_imm;
    logic [BW-1:0]         imm;
    logic [BW-1:0]         exp_result;
    alu_flags_t            exp_flags;
  } stim_entry_t;

  stim_entry_t   stim [NUM_ENTRIES];
  // shadow of the register file, updated when an instruction issues
  logic [BW-1:0] shadow [NUM_REGS];
  logic [31:0]   lfsr_q;
  // outputs expected after the next edge
  logic [BW-1:0] pend_result;
  alu_flags_t    pend_flags;
  logic          pend_valid;
  int            result_errs;
  int            flag_errs;
  int            reg_errs;
  int            table_errs;

  alu_datapath #(
    .BW(BW)
  ) alu_datapath_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .instr_valid_i(instr_valid_i),
    .op_i         (op_i),
    .rs_a_i       (rs_a_i),
    .rs_b_i       (rs_b_i),
    .rd_i         (rd_i),
    .use_imm_i    (use_imm_i),
    .imm_i        (imm_i),
    .dbg_addr_i   (dbg_addr_i),
    .result_o     (result_o),
    .flags_o      (flags_o),
    .dbg_data_o   (dbg_data_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //------------------------------------------------------------------
  // random source and reference model
  //------------------------------------------------------------------

  // galois lfsr, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // arithmetic on plain signed integers, overflow = out of signed range
  task automatic predict(input alu_op_e op, input logic [BW-1:0] a,
                         input logic [BW-1:0] b, output logic [BW-1:0] res,
                         output alu_flags_t flg);
    int   sa;
    int   sb;
    int   full;
    logic arith;
    sa = int'($signed(a));
    sb = int'($signed(b));
    full = 0;
    arith = 1'b1;
    case (op)
      OP_ADD:  full = sa + sb;
      OP_SUB:  full = sa - sb;
      OP_INC:  full = sa + 1;
      default: arith = 1'b0;
    endcase
    case (op)
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_MOVA: res = a;
      OP_MOVB: res = b;
      default: res = full[BW-1:0];
    endcase
    flg.overflow = arith && (full > (2 ** (BW - 1)) - 1 || full < -(2 ** (BW - 1)));
    flg.negative = res[BW-1];
    flg.zero     = (res == '0);
  endtask

  //------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------

  task automatic check_result(input logic [BW-1:0] exp, input logic [BW-1:0] act);
    if (act !== exp) begin
      result_errs++;
      $display("FAIL t=%0t result_o expected %h got %h", $time, exp, act);
    end
  endtask

  task automatic check_flags(input alu_flags_t exp, input alu_flags_t act);
    if (act !== exp) begin
      flag_errs++;
      $display("FAIL t=%0t flags_o expected %b got %b", $time, exp, act);
    end
  endtask

  task automatic check_reg(input int addr, input logic [BW-1:0] exp,
                           input logic [BW-1:0] act);
    if (act !== exp) begin
      reg_errs++;
      $display("FAIL t=%0t dbg_data_o r%0d expected %h got %h", $time, addr, exp, act);
    end
  endtask

  // walk the debug port over every register, dut idle
  task automatic check_all_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      dbg_addr_i = REG_ADDR_W'(r);
      #1;
      check_reg(r, shadow[r], dbg_data_o);
    end
  endtask

  //------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------

  task automatic set_entry(input int idx, input logic iss, input alu_op_e op,
                           input logic [REG_ADDR_W-1:0] ra, input logic [REG_ADDR_W-1:0] rb,
                           input logic [REG_ADDR_W-1:0] rd, input logic ui,
                           input logic [BW-1:0] imm, input logic [BW-1:0] er,
                           input logic [2:0] ef);
    stim[idx] = '{iss, op, ra, rb, rd, ui, imm, er, alu_flags_t'(ef)};
  endtask

  // columns: index, issue, op, rs_a, rs_b, rd, use_imm, imm, result, flags (o n z)
  task automatic load_table();
    set_entry(0,  1'b1, OP_MOVB, 2'd0, 2'd0, 2'd0, 1'b1, 8'h7f, 8'h7f, 3'b000);
    set_entry(1,  1'b1, OP_MOVB, 2'd0, 2'd0, 2'd1, 1'b1, 8'h01, 8'h01, 3'b000);
    // 127 + 1
    set_entry(2,  1'b1, OP_ADD,  2'd0, 2'd1, 2'd2, 1'b0, 8'h00, 8'h80, 3'b110);
    set_entry(3,  1'b1, OP_MOVB, 2'd0, 2'd0, 2'd3, 1'b1, 8'h80, 8'h80, 3'b010);
    // -128 - 1, reads r3 written just before
    set_entry(4,  1'b1, OP_SUB,  2'd3, 2'd1, 2'd3, 1'b0, 8'h00, 8'h7f, 3'b100);
    set_entry(5,  1'b1, OP_INC,  2'd0, 2'd0, 2'd2, 1'b0, 8'h00, 8'h80, 3'b110);
    set_entry(6,  1'b1, OP_SUB,  2'd1, 2'd0, 2'd1, 1'b1, 8'h01, 8'h00, 3'b001);
    set_entry(7,  1'b1, OP_ADD,  2'd1, 2'd0, 2'd1, 1'b1, 8'h05, 8'h05, 3'b000);
    // idle, would clobber r3 if it wrote
    set_entry(8,  1'b0, OP_MOVB, 2'd0, 2'd0, 2'd3, 1'b1, 8'hff, 8'h05, 3'b000);
    set_entry(9,  1'b1, OP_AND,  2'd2, 2'd3, 2'd2, 1'b0, 8'h00, 8'h00, 3'b001);
    set_entry(10, 1'b1, OP_OR,   2'd3, 2'd0, 2'd0, 1'b1, 8'h80, 8'hff, 3'b010);
    set_entry(11, 1'b1, OP_XOR,  2'd0, 2'd3, 2'd1, 1'b0, 8'h00, 8'h80, 3'b010);
    set_entry(12, 1'b1, OP_MOVA, 2'd1, 2'd0, 2'd2, 1'b0, 8'h00, 8'h80, 3'b010);
    set_entry(13, 1'b1, OP_XOR,  2'd0, 2'd0, 2'd3, 1'b0, 8'h00, 8'h00, 3'b001);
    set_entry(14, 1'b1, OP_ADD,  2'd0, 2'd0, 2'd0, 1'b0, 8'h00, 8'hfe, 3'b010);
    set_entry(15, 1'b1, OP_INC,  2'd0, 2'd0, 2'd0, 1'b0, 8'h00, 8'hff, 3'b010);
    set_entry(16, 1'b1, OP_INC,  2'd0, 2'd0, 2'd0, 1'b0, 8'h00, 8'h00, 3'b001);
    set_entry(17, 1'b1, OP_SUB,  2'd1, 2'd0, 2'd1, 1'b0, 8'h00, 8'h80, 3'b010);
    // 0 - (-128)
    set_entry(18, 1'b1, OP_SUB,  2'd3, 2'd1, 2'd3, 1'b0, 8'h00, 8'h80, 3'b110);
    set_entry(19, 1'b1, OP_MOVB, 2'd0, 2'd3, 2'd2, 1'b0, 8'h00, 8'h80, 3'b010);
    set_entry(20, 1'b1, OP_ADD,  2'd1, 2'd0, 2'd1, 1'b1, 8'h80, 8'h00, 3'b101);
  endtask

  // next edge, then check what the previous instruction left behind
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
    if (pend_valid) begin
      check_result(pend_result, result_o);
      check_flags(pend_flags, flags_o);
    end
  endtask

  // model on the shadow, then drive the dut pins
  task automatic apply_instr(input logic iss, input alu_op_e op,
                             input logic [REG_ADDR_W-1:0] ra, input logic [REG_ADDR_W-1:0] rb,
                             input logic [REG_ADDR_W-1:0] rd, input logic ui,
                             input logic [BW-1:0] imm, output logic [BW-1:0] mres,
                             output alu_flags_t mflg);
    logic [BW-1:0] b_val;
    b_val = ui ? imm : shadow[rb];
    predict(op, shadow[ra], b_val, mres, mflg);
    if (iss) begin
      shadow[rd] = mres;
    end
    instr_valid_i = iss;
    op_i          = op;
    rs_a_i        = ra;
    rs_b_i        = rb;
    rd_i          = rd;
    use_imm_i     = ui;
    imm_i         = imm;
  endtask

  task automatic drain();
    step_cycle();
    instr_valid_i = 1'b0;
    pend_valid    = 1'b0;
  endtask

  task automatic run_directed();
    logic [BW-1:0] mres;
    alu_flags_t    mflg;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      step_cycle();
      apply_instr(stim[i].issue, stim[i].op, stim[i].rs_a, stim[i].rs_b, stim[i].rd,
                  stim[i].use_imm, stim[i].imm, mres, mflg);
      // table expectations cross-checked against the model
      if (stim[i].issue && (mres !== stim[i].exp_result || mflg !== stim[i].exp_flags)) begin
        table_errs++;
        $display("table entry %0d disagrees with the reference model", i);
      end
      pend_result = stim[i].exp_result;
      pend_flags  = stim[i].exp_flags;
      pend_valid  = 1'b1;
    end
    drain();
  endtask

  task automatic run_random();
    logic [31:0]   bits;
    logic [BW-1:0] mres;
    alu_flags_t    mflg;
    alu_op_e       op;
    logic [1:0]    ra;
    logic [1:0]    rb;
    logic [1:0]    rd;
    logic          ui;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      step_cycle();
      take_bits(3, bits);
      op = alu_op_e'(bits[2:0]);
      take_bits(2, bits);
      ra = bits[1:0];
      take_bits(2, bits);
      rb = bits[1:0];
      take_bits(2, bits);
      rd = bits[1:0];
      take_bits(1, bits);
      ui = bits[0];
      take_bits(BW, bits);
      apply_instr(1'b1, op, ra, rb, rd, ui, bits[BW-1:0], mres, mflg);
      pend_result = mres;
      pend_flags  = mflg;
      pend_valid  = 1'b1;
    end
    drain();
  endtask

  //------------------------------------------------------------------
  // main sequence and watchdog
  //------------------------------------------------------------------

  initial begin
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    op_i          = OP_ADD;
    rs_a_i        = '0;
    rs_b_i        = '0;
    rd_i          = '0;
    use_imm_i     = 1'b0;
    imm_i         = '0;
    dbg_addr_i    = '0;
    lfsr_q        = 32'h31b5;
    pend_result   = '0;
    pend_flags    = '0;
    pend_valid    = 1'b0;
    result_errs   = 0;
    flag_errs     = 0;
    reg_errs      = 0;
    table_errs    = 0;
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = '0;
    end
    load_table();
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // everything cleared by reset
    check_result('0, result_o);
    check_flags('0, flags_o);
    check_all_regs();
    run_directed();
    check_all_regs();
    run_random();
    check_all_regs();
    $display("errors: result %0d, flags %0d, registers %0d, table %0d",
             result_errs, flag_errs, reg_errs, table_errs);
    if (result_errs + flag_errs + reg_errs + table_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule
